/* verilog/tlb_cfg.svh */
// *************************************************************************
// TLB configuration
// *************************************************************************

`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// number of entries, must be a power of two for the replacement tree
`define TLB_ENTRIES 8

// virtual page number width
`define TLB_VPN_W 20

// physical page number width
`define TLB_PPN_W 16

`endif

/* verilog/tlb_pkg.sv */
// *************************************************************************
// TLB shared types
// *************************************************************************

`include "tlb_cfg.svh"

package tlb_pkg;

    // virtual page number as presented on lookup and fill
    typedef logic [`TLB_VPN_W-1:0] vpn_t;

    // physical page number returned on a hit
    typedef logic [`TLB_PPN_W-1:0] ppn_t;

    // one bit per entry
    // shared by the valid, hit, used and victim vectors
    typedef logic [`TLB_ENTRIES-1:0] entry_vec_t;

endpackage

/* verilog/plru_tree.sv */
// *************************************************************************
// Pseudo LRU replacement tree
// *************************************************************************

module plru_tree #(
    parameter int unsigned ENTRIES = 8
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    // one hot, entry i was used this cycle
    input  logic [ENTRIES-1:0] used_i,
    // one hot, entry i is the replacement candidate
    output logic [ENTRIES-1:0] plru_o
);

    localparam int unsigned LogEntries = $clog2(ENTRIES);
    // one node per internal position of a full binary tree
    localparam int unsigned Nodes = ENTRIES - 1;

    // node n has children 2n+1 (left) and 2n+2 (right)
    // level l starts at node 2**l - 1
    logic [Nodes-1:0] tree_q;
    logic [Nodes-1:0] tree_d;

    // point every node on the used path away from the used entry
    always_comb begin : tree_update
        int unsigned node;
        tree_d = tree_q;
        node   = 0;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            if (used_i[i]) begin
                for (int unsigned lvl = 0; lvl < LogEntries; lvl++) begin
                    // first node of this level plus the path prefix above it
                    node = (2 ** lvl - 1) + (i >> (LogEntries - lvl));
                    // msb of the index decides at the root
                    tree_d[node] = ~i[LogEntries-1-lvl];
                end
            end
        end
    end

    // walk the tree from the root, a set node selects the right child
    // an entry is the victim when every node on its path agrees with its index
    always_comb begin : victim_decode
        int unsigned node;
        logic        match;
        plru_o = '0;
        node   = 0;
        match  = 1'b0;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            match = 1'b1;
            for (int unsigned lvl = 0; lvl < LogEntries; lvl++) begin
                node  = (2 ** lvl - 1) + (i >> (LogEntries - lvl));
                match = match & (tree_q[node] == i[LogEntries-1-lvl]);
            end
            plru_o[i] = match;
        end
    end

    // tree bits are control state, all zero after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tree_q <= '0;
        end else begin
            tree_q <= tree_d;
        end
    end

    // the tree only has a unique path per entry for a power of two
    initial begin
        assert (ENTRIES >= 2 && ENTRIES == 2 ** LogEntries)
            else $error("plru_tree needs a power of two entry count");
    end

    // after a use the single victim must lie away from the entry just used
    victim_onehot : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        |used_i |=> $onehot(plru_o) && ((plru_o & $past(used_i)) == '0))
        else $error("plru_tree names the entry it just marked as used");

endmodule

/* verilog/tlb_lookup.sv */
// *************************************************************************
// TLB tag compare
// *************************************************************************

`include "tlb_cfg.svh"

module tlb_lookup import tlb_pkg::*; (
    input  logic                       lookup_i,
    input  vpn_t                       lookup_vpn_i,
    // state of the entry store
    input  entry_vec_t                 valid_i,
    input  vpn_t [`TLB_ENTRIES-1:0]    tags_i,
    // one hot hit, qualified by the strobe
    output entry_vec_t                 hit_vec_o
);

    // raw tag matches before qualification
    entry_vec_t tag_match;

    // all entries are compared in parallel, fully associative
    always_comb begin : tag_compare
        for (int unsigned i = 0; i < `TLB_ENTRIES; i++) begin
            tag_match[i] = (tags_i[i] == lookup_vpn_i);
        end
    end

    // an invalid entry never hits, even if a stale tag still matches
    // without a strobe the vector stays zero, so neither the tree nor
    // the response stage see a spurious hit
    assign hit_vec_o = tag_match & valid_i & {`TLB_ENTRIES{lookup_i}};

    // fills never reuse a present page, so two live tags can never match
    // a second hit here means the entry store took a duplicate fill
    always_comb begin : dup_check
        assert ($onehot0(hit_vec_o))
            else $error("tlb_lookup hit in more than one entry");
    end

endmodule

/* verilog/tlb_entry_store.sv */
// *************************************************************************
// TLB entry store and fill
// *************************************************************************

`include "tlb_cfg.svh"

module tlb_entry_store import tlb_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // fill from the walker side
    input  logic                       fill_i,
    input  vpn_t                       fill_vpn_i,
    input  ppn_t                       fill_ppn_i,
    input  logic                       flush_i,
    // lookup result from the decode stage
    input  logic                       lookup_i,
    input  entry_vec_t                 hit_vec_i,
    // entry state towards lookup and response
    output entry_vec_t                 valid_o,
    output vpn_t [`TLB_ENTRIES-1:0]    tags_o,
    output ppn_t [`TLB_ENTRIES-1:0]    ppns_o
);

    entry_vec_t              valid_q;
    vpn_t [`TLB_ENTRIES-1:0] tags_q;
    ppn_t [`TLB_ENTRIES-1:0] ppns_q;

    // lowest invalid entry, one hot, zero when the buffer is full
    entry_vec_t first_free;
    // victim proposed by the tree
    entry_vec_t plru_victim;
    // one hot target of the current fill
    entry_vec_t fill_vec;
    // entry touched this cycle, fed back into the tree
    entry_vec_t used_vec;

    // adding one to the valid vector carries through the low run of ones
    // and stops at the lowest zero, which is the first free entry
    assign first_free = ~valid_q & (valid_q + entry_vec_t'(1));

    // free entries win over the tree
    assign fill_vec = (|first_free) ? first_free : plru_victim;

    // a hit and a fill both count as a use
    assign used_vec = ({`TLB_ENTRIES{lookup_i}} & hit_vec_i)
                    | ({`TLB_ENTRIES{fill_i}} & fill_vec);

    plru_tree #(
        .ENTRIES (`TLB_ENTRIES)
    ) u_plru_tree (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .used_i (used_vec),
        .plru_o (plru_victim)
    );

    // valid bits, flush clears all of them and leaves the tree alone
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q <= valid_q | fill_vec;
        end
    end

    // tag and translation payload, only the fill target is written
    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            for (int unsigned i = 0; i < `TLB_ENTRIES; i++) begin
                if (fill_vec[i]) begin
                    tags_q[i] <= fill_vpn_i;
                    ppns_q[i] <= fill_ppn_i;
                end
            end
        end
    end

    assign valid_o = valid_q;
    assign tags_o  = tags_q;
    assign ppns_o  = ppns_q;

    // the used vector assumes a lookup never shares a cycle with a fill
    strobe_exclusive : assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot0({lookup_i, fill_i, flush_i}))
        else $error("tlb strobes lookup, fill and flush overlap");

endmodule

/* verilog/tlb_resp.sv */
// *************************************************************************
// TLB response register
// *************************************************************************

`include "tlb_cfg.svh"

module tlb_resp import tlb_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       lookup_i,
    input  entry_vec_t                 hit_vec_i,
    input  ppn_t [`TLB_ENTRIES-1:0]    ppns_i,
    // response, one cycle after the lookup
    output logic                       resp_valid_o,
    output logic                       hit_o,
    output ppn_t                       ppn_o
);

    ppn_t ppn_sel;
    logic resp_valid_q;
    logic hit_q;
    ppn_t ppn_q;

    // one hot mux, a miss leaves every term masked so the result is zero
    always_comb begin : ppn_select
        ppn_sel = '0;
        for (int unsigned i = 0; i < `TLB_ENTRIES; i++) begin
            ppn_sel = ppn_sel | ({`TLB_PPN_W{hit_vec_i[i]}} & ppns_i[i]);
        end
    end

    // strobe and hit flag
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resp_valid_q <= 1'b0;
            hit_q        <= 1'b0;
        end else begin
            resp_valid_q <= lookup_i;
            hit_q        <= |hit_vec_i;
        end
    end

    // captured every cycle, zero whenever there was no hit
    always_ff @(posedge clk_i) begin
        ppn_q <= ppn_sel;
    end

    assign resp_valid_o = resp_valid_q;
    assign hit_o        = hit_q;
    assign ppn_o        = ppn_q;

endmodule

/* verilog/tlb.sv */
// *************************************************************************
// TLB top level
// *************************************************************************

`include "tlb_cfg.svh"

module tlb import tlb_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    // lookup request
    input  logic lookup_i,
    input  vpn_t lookup_vpn_i,
    // fill from the walker
    input  logic fill_i,
    input  vpn_t fill_vpn_i,
    input  ppn_t fill_ppn_i,
    input  logic flush_i,
    // registered response
    output logic resp_valid_o,
    output logic hit_o,
    output ppn_t ppn_o
);

    entry_vec_t              hit_vec;
    entry_vec_t              valid;
    vpn_t [`TLB_ENTRIES-1:0] tags;
    ppn_t [`TLB_ENTRIES-1:0] ppns;

    // decode, parallel tag compare
    tlb_lookup u_tlb_lookup (
        .lookup_i     (lookup_i),
        .lookup_vpn_i (lookup_vpn_i),
        .valid_i      (valid),
        .tags_i       (tags),
        .hit_vec_o    (hit_vec)
    );

    // execute, entries and replacement
    tlb_entry_store u_tlb_entry_store (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .fill_i     (fill_i),
        .fill_vpn_i (fill_vpn_i),
        .fill_ppn_i (fill_ppn_i),
        .flush_i    (flush_i),
        .lookup_i   (lookup_i),
        .hit_vec_i  (hit_vec),
        .valid_o    (valid),
        .tags_o     (tags),
        .ppns_o     (ppns)
    );

    // result, registered response
    tlb_resp u_tlb_resp (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .lookup_i     (lookup_i),
        .hit_vec_i    (hit_vec),
        .ppns_i       (ppns),
        .resp_valid_o (resp_valid_o),
        .hit_o        (hit_o),
        .ppn_o        (ppn_o)
    );

endmodule

/* sim/tlb_checker.sv */
// *************************************************************************
// TLB response checker
// *************************************************************************

`include "tlb_cfg.svh"

module tlb_checker import tlb_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    // strobes and operands as seen by the DUT
    input  logic lookup_i,
    input  vpn_t lookup_vpn_i,
    input  logic fill_i,
    input  vpn_t fill_vpn_i,
    input  ppn_t fill_ppn_i,
    input  logic flush_i,
    // registered DUT response
    input  logic resp_valid_i,
    input  logic hit_i,
    input  ppn_t ppn_i,
    // test sequencing from the testbench top
    input  logic test_end_i,
    input  int   test_num_i,
    input  logic report_i,
    output int   fail_count_o
);

    localparam int Entries = `TLB_ENTRIES;
    localparam int Levels  = $clog2(Entries);

    // reference copy of the entries
    vpn_t m_tags  [Entries];
    ppn_t m_ppns  [Entries];
    bit   m_valid [Entries];
    // reference tree, node 0 is the root
    bit   m_tree  [Entries-1];

    // response expected at the next sample
    bit   exp_pending;
    bit   exp_hit;
    ppn_t exp_ppn;

    int test_checks;
    int test_errors;
    int total_checks;
    int total_errors;
    int tests_passed;
    int tests_failed;

    assign fail_count_o = total_errors;

    function automatic string test_name(input int num);
        case (num)
            1: return "miss after reset";
            2: return "fill in order and hit";
            3: return "tree picks the victim";
            4: return "flush and refill";
            5: return "back-to-back lookups";
            6: return "random mix";
            default: return "unnamed";
        endcase
    endfunction

    // index of the valid entry holding vpn, -1 on a miss
    function automatic int find_entry(input vpn_t vpn);
        for (int i = 0; i < Entries; i++) begin
            if (m_valid[i] && m_tags[i] == vpn) begin
                return i;
            end
        end
        return -1;
    endfunction

    // walk down from the root, each node points away from the used entry
    function automatic void mark_used(input int idx);
        int node;
        int b;
        node = 0;
        for (int lvl = 0; lvl < Levels; lvl++) begin
            b = (idx >> (Levels - 1 - lvl)) & 1;
            m_tree[node] = (b == 0);
            node = 2 * node + 1 + b;
        end
    endfunction

    // follow the node values, a one goes right
    function automatic int tree_victim();
        int node;
        int idx;
        int b;
        node = 0;
        idx  = 0;
        for (int lvl = 0; lvl < Levels; lvl++) begin
            b    = int'(m_tree[node]);
            idx  = 2 * idx + b;
            node = 2 * node + 1 + b;
        end
        return idx;
    endfunction

    // lowest invalid entry first, otherwise the tree decides
    function automatic int fill_slot();
        for (int i = 0; i < Entries; i++) begin
            if (!m_valid[i]) begin
                return i;
            end
        end
        return tree_victim();
    endfunction

    task automatic report_mismatch(input string msg);
        $display("FAIL at time %0t: %s", $time, msg);
        test_errors++;
        total_errors++;
    endtask

    task automatic close_test(input int num);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d, %s: passed, %0d responses checked",
                     num, test_name(num), test_checks);
        end else begin
            tests_failed++;
            $display("FAIL at time %0t: test %0d, %s: %0d mismatches",
                     $time, num, test_name(num), test_errors);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // sampled mid cycle, inputs and registered outputs are both settled
    always @(negedge clk_i) begin : model_step
        int idx;
        if (!rst_ni) begin
            for (int i = 0; i < Entries; i++) begin
                m_valid[i] = 1'b0;
            end
            for (int n = 0; n < Entries - 1; n++) begin
                m_tree[n] = 1'b0;
            end
            exp_pending = 1'b0;
        end else begin
            // the response now belongs to the lookup sampled one cycle ago
            if (resp_valid_i !== exp_pending) begin
                report_mismatch($sformatf("resp_valid_o is %b, expected %b",
                                          resp_valid_i, exp_pending));
            end else if (exp_pending) begin
                test_checks++;
                total_checks++;
                if (hit_i !== exp_hit || ppn_i !== exp_ppn) begin
                    report_mismatch($sformatf("hit %b ppn %h, expected hit %b ppn %h",
                                              hit_i, ppn_i, exp_hit, exp_ppn));
                end
            end
            exp_pending = lookup_i;
            if (lookup_i) begin
                idx     = find_entry(lookup_vpn_i);
                exp_hit = (idx >= 0);
                exp_ppn = exp_hit ? m_ppns[idx] : '0;
                if (exp_hit) begin
                    mark_used(idx);
                end
            end else if (fill_i) begin
                idx          = fill_slot();
                m_tags[idx]  = fill_vpn_i;
                m_ppns[idx]  = fill_ppn_i;
                m_valid[idx] = 1'b1;
                mark_used(idx);
            end else if (flush_i) begin
                // tree stays as it is
                for (int i = 0; i < Entries; i++) begin
                    m_valid[i] = 1'b0;
                end
            end
            if (test_end_i) begin
                close_test(test_num_i);
            end
            if (report_i) begin
                $display("tests passed %0d, failed %0d, responses checked %0d, mismatches %0d",
                         tests_passed, tests_failed, total_checks, total_errors);
            end
        end
    end

endmodule

/* sim/tb_tlb.sv */
// *************************************************************************
// TLB testbench
// *************************************************************************

`include "tlb_cfg.svh"

module tb_tlb import tlb_pkg::*; ();

    localparam int Entries   = `TLB_ENTRIES;
    localparam int RandIters = 400;
    localparam int PoolSize  = 24;
    // operations per test, a random step is one lookup plus at most
    // one fill or flush
    localparam int TotalOps  = 16 + 2 * Entries + (Entries + 6) + (Entries + 6) + 8
                             + 2 * RandIters;
    localparam int MaxCycles = 3 * TotalOps + 100;

    logic clk;
    logic rst_n;
    logic lookup;
    vpn_t lookup_vpn;
    logic fill;
    vpn_t fill_vpn;
    ppn_t fill_ppn;
    logic flush;
    logic resp_valid;
    logic hit;
    ppn_t ppn;
    logic test_end;
    int   test_num;
    logic report;
    int   fail_count;
    int   cycles = 0;

    // directed pages and the random page pool
    vpn_t pages [Entries + 3];
    vpn_t pool  [PoolSize];

    tlb u_tlb (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .lookup_i     (lookup),
        .lookup_vpn_i (lookup_vpn),
        .fill_i       (fill),
        .fill_vpn_i   (fill_vpn),
        .fill_ppn_i   (fill_ppn),
        .flush_i      (flush),
        .resp_valid_o (resp_valid),
        .hit_o        (hit),
        .ppn_o        (ppn)
    );

    tlb_checker u_tlb_checker (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .lookup_i     (lookup),
        .lookup_vpn_i (lookup_vpn),
        .fill_i       (fill),
        .fill_vpn_i   (fill_vpn),
        .fill_ppn_i   (fill_ppn),
        .flush_i      (flush),
        .resp_valid_i (resp_valid),
        .hit_i        (hit),
        .ppn_i        (ppn),
        .test_end_i   (test_end),
        .test_num_i   (test_num),
        .report_i     (report),
        .fail_count_o (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run length guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MaxCycles) begin
            $display("timeout: the test sequence did not finish within %0d cycles", MaxCycles);
            $display("Test failed");
            $finish;
        end
    end

    // move to the drive point of the next cycle with all strobes low
    task automatic next_cycle();
        @(posedge clk);
        #2;
        lookup   = 1'b0;
        fill     = 1'b0;
        flush    = 1'b0;
        test_end = 1'b0;
        report   = 1'b0;
    endtask

    task automatic issue_lookup(input vpn_t vpn);
        next_cycle();
        lookup     = 1'b1;
        lookup_vpn = vpn;
    endtask

    task automatic issue_fill(input vpn_t vpn, input ppn_t pn);
        next_cycle();
        fill     = 1'b1;
        fill_vpn = vpn;
        fill_ppn = pn;
    endtask

    task automatic issue_flush();
        next_cycle();
        flush = 1'b1;
    endtask

    // the walker only needs the hit flag, the checker judges the values
    task automatic lookup_and_wait(input vpn_t vpn, output logic was_hit);
        issue_lookup(vpn);
        next_cycle();
        while (!resp_valid) begin
            next_cycle();
        end
        was_hit = hit;
    endtask

    task automatic end_test(input int num);
        next_cycle();
        test_end = 1'b1;
        test_num = num;
    endtask

    initial begin : stimulus
        logic        h;
        vpn_t        vpn;
        int unsigned base;
        void'($urandom(32'h3bb4_752c));
        rst_n      = 1'b0;
        lookup     = 1'b0;
        lookup_vpn = '0;
        fill       = 1'b0;
        fill_vpn   = '0;
        fill_ppn   = '0;
        flush      = 1'b0;
        test_end   = 1'b0;
        test_num   = 0;
        report     = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // empty buffer misses every page
        for (int n = 0; n < 16; n++) begin
            lookup_and_wait(vpn_t'($urandom), h);
        end
        end_test(1);

        // distinct pages fill entries 0 upward, then each one hits
        base = $urandom;
        for (int i = 0; i < Entries + 3; i++) begin
            pages[i] = vpn_t'(base + 37 * i);
        end
        for (int i = 0; i < Entries; i++) begin
            issue_fill(pages[i], ppn_t'($urandom));
        end
        for (int i = 0; i < Entries; i++) begin
            lookup_and_wait(pages[i], h);
        end
        end_test(2);

        // hits steer the tree, the next fill evicts the entry it names
        lookup_and_wait(pages[3 % Entries], h);
        lookup_and_wait(pages[6 % Entries], h);
        lookup_and_wait(pages[1], h);
        lookup_and_wait(pages[0], h);
        issue_fill(pages[Entries], ppn_t'($urandom));
        for (int i = 0; i <= Entries; i++) begin
            lookup_and_wait(pages[i], h);
        end
        end_test(3);

        // everything misses after a flush, refills restart at entry 0
        issue_flush();
        for (int i = 0; i <= Entries; i++) begin
            lookup_and_wait(pages[i], h);
        end
        issue_fill(pages[Entries + 1], ppn_t'($urandom));
        issue_fill(pages[Entries + 2], ppn_t'($urandom));
        lookup_and_wait(pages[Entries + 1], h);
        lookup_and_wait(pages[Entries + 2], h);
        end_test(4);

        // one lookup per cycle, present and absent pages interleaved
        for (int n = 0; n < 8; n++) begin
            issue_lookup((n % 2 == 0) ? pages[Entries + 1 + (n / 2) % 2] : vpn_t'($urandom));
        end
        next_cycle();
        end_test(5);

        // pool larger than the buffer, so misses and evictions keep coming
        base = $urandom;
        for (int i = 0; i < PoolSize; i++) begin
            pool[i] = vpn_t'(base + 53 * i);
        end
        for (int n = 0; n < RandIters; n++) begin
            vpn = pool[$urandom_range(PoolSize - 1, 0)];
            lookup_and_wait(vpn, h);
            // walker fills most misses, the page was just seen absent
            if (!h && $urandom_range(9, 0) < 7) begin
                issue_fill(vpn, ppn_t'($urandom));
            end else if ($urandom_range(99, 0) < 3) begin
                issue_flush();
            end
        end
        end_test(6);

        next_cycle();
        report = 1'b1;
        next_cycle();
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tlb.f */
+incdir+verilog
verilog/tlb_pkg.sv
verilog/plru_tree.sv
verilog/tlb_lookup.sv
verilog/tlb_entry_store.sv
verilog/tlb_resp.sv
verilog/tlb.sv
sim/tlb_checker.sv
sim/tb_tlb.sv

/* Makefile */
# Verilator simulation of the TLB testbench

VERILATOR ?= verilator
TOP       ?= tb_tlb
FILELIST  ?= tlb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

# build, run into the log, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
